/* soc_consts.svh */
// shared constants for the data-side memory bus
//   slave base addresses and spans
//   spram depth in 32-bit words
//   timer register offsets
//   reset value of the latched transaction address
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// spram window, 128 KiB of 32-bit words
`define SPRAM_BASE     32'hf0000000
`define SPRAM_WORDS    32768

// timer register block
`define TIMER_BASE     32'h80000000
// ctrl: bit0 enable, bit1 irq enable
`define TIMER_CTRL_OFS 4'h0
`define TIMER_CMP_OFS  4'h4
// count is read only
`define TIMER_CNT_OFS  4'h8
// status: bit0 match, write 1 to clear
`define TIMER_STAT_OFS 4'hc
`define TIMER_SPAN     32'd16

// no access seen yet
`define XACT_NONE      32'hffffffff

`endif

/* soc_pkg.sv */
// bus and timer types for the data-side memory bus
//   bus address, data and byte mask vectors
//   spram macro address and half-word
//   timer count type and counter state enum
package soc_pkg;

    // byte address seen by every slave
    typedef logic [31:0] bus_addr_t;

    // read or write data word
    typedef logic [31:0] bus_data_t;

    // one bit per byte lane
    typedef logic [3:0] bus_mask_t;

    // word index inside one 16K x 16 macro
    typedef logic [13:0] spram_addr_t;

    // data half of one macro
    typedef logic [15:0] spram_half_t;

    // timer count and compare
    typedef logic [31:0] timer_count_t;

    // counter fsm
    typedef enum logic [1:0] {
        TIMER_IDLE    = 2'd0,
        TIMER_RUN     = 2'd1,
        TIMER_MATCHED = 2'd2
    } timer_state_e;

endpackage

/* spram_256k.sv */
// behavioral model of one 16K x 16 single-port ram macro
//   nibble write mask, chip select
//   registered read port
//   power modes are not modelled
`timescale 1ns/1ps

module spram_256k (
    input  logic                clk,
    input  soc_pkg::spram_addr_t address,
    input  soc_pkg::spram_half_t datain,
    input  logic [3:0]          maskwren,
    input  logic                wren,
    input  logic                chipselect,
    output soc_pkg::spram_half_t dataout
);

    // 16K half-words
    localparam int DEPTH = 16384;

    soc_pkg::spram_half_t mem [0:DEPTH-1];

    // write port, one enable per nibble
    always_ff @(posedge clk) begin
        if (chipselect && wren) begin
            for (int n = 0; n < 4; n++) begin
                if (maskwren[n]) begin
                    mem[address][n*4 +: 4] <= datain[n*4 +: 4];
                end
            end
        end
    end

    // read port
    // dataout only moves on a selected read, holds otherwise
    always_ff @(posedge clk) begin
        if (chipselect && !wren) begin
            dataout <= mem[address];
        end
    end

endmodule

/* ice40_spram.sv */
// 32-bit spram slave over four 16K x 16 macros
//   address window decode and bank pair select
//   byte mask to nibble mask expansion
//   done tracking through the latched transaction address
`timescale 1ns/1ps
`include "soc_consts.svh"

module ice40_spram #(
    parameter int                 WORDS     = `SPRAM_WORDS,
    parameter soc_pkg::bus_addr_t BASE_ADDR = `SPRAM_BASE
) (
    input  logic               clk,
    input  logic               rst_n,
    input  soc_pkg::bus_addr_t addr,
    input  soc_pkg::bus_data_t wdata,
    input  soc_pkg::bus_mask_t wmask,
    input  logic               wen,
    input  logic               ren,
    output soc_pkg::bus_data_t rdata,
    output logic               done,
    output logic               active
);

    // window size in bytes
    localparam soc_pkg::bus_addr_t SPAN = WORDS * 4;
    // byte offset bit that picks the bank pair
    localparam int BANK_BIT = $clog2(WORDS) + 1;

    soc_pkg::bus_addr_t   offset;
    soc_pkg::spram_addr_t word_idx;
    logic                 bank;
    logic                 we;
    logic                 cs_0;
    logic                 cs_1;
    logic [3:0]           nib_lo;
    logic [3:0]           nib_hi;
    soc_pkg::spram_half_t d00, d01, d10, d11;
    soc_pkg::bus_addr_t   xact_addr;

    assign active = (addr >= BASE_ADDR) && (addr < BASE_ADDR + SPAN);

    assign offset   = addr - BASE_ADDR;
    assign word_idx = offset[BANK_BIT-1:2];
    assign bank     = offset[BANK_BIT];

    // writes only inside the window
    assign we = wen & active;

    // each byte lane covers two nibbles of its macro
    assign nib_lo = {wmask[1], wmask[1], wmask[0], wmask[0]};
    assign nib_hi = {wmask[3], wmask[3], wmask[2], wmask[2]};

    assign cs_0 = active & ~bank;
    assign cs_1 = active & bank;

    // bank 0, low and high halves
    spram_256k ram00 (
        .clk        (clk),
        .address    (word_idx),
        .datain     (wdata[15:0]),
        .maskwren   (nib_lo),
        .wren       (we),
        .chipselect (cs_0),
        .dataout    (d00)
    );

    spram_256k ram01 (
        .clk        (clk),
        .address    (word_idx),
        .datain     (wdata[31:16]),
        .maskwren   (nib_hi),
        .wren       (we),
        .chipselect (cs_0),
        .dataout    (d01)
    );

    // bank 1
    spram_256k ram10 (
        .clk        (clk),
        .address    (word_idx),
        .datain     (wdata[15:0]),
        .maskwren   (nib_lo),
        .wren       (we),
        .chipselect (cs_1),
        .dataout    (d10)
    );

    spram_256k ram11 (
        .clk        (clk),
        .address    (word_idx),
        .datain     (wdata[31:16]),
        .maskwren   (nib_hi),
        .wren       (we),
        .chipselect (cs_1),
        .dataout    (d11)
    );

    // bank select follows the held address
    assign rdata = bank ? {d11, d10} : {d01, d00};

    // done once the held address matches the last sampled access
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xact_addr <= `XACT_NONE;
        end else if (ren || wen) begin
            xact_addr <= addr;
        end
    end

    assign done = active & (xact_addr == addr);

endmodule

/* timer_counter.sv */
// timer counter steered by the timer register block
//   free-running count while enabled
//   restart on compare, sticky match flag
`timescale 1ns/1ps

module timer_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  soc_pkg::timer_count_t compare,
    input  logic                  clear_match,
    output soc_pkg::timer_count_t count,
    output logic                  match
);

    soc_pkg::timer_state_e state;
    soc_pkg::timer_state_e state_nxt;
    logic                  hit;

    // compare hit only counts while running
    assign hit = enable && (count == compare);

    // new hit beats a clear in the same cycle
    always_comb begin
        if (hit) begin
            state_nxt = soc_pkg::TIMER_MATCHED;
        end else if (state == soc_pkg::TIMER_MATCHED && !clear_match) begin
            state_nxt = soc_pkg::TIMER_MATCHED;
        end else if (enable) begin
            state_nxt = soc_pkg::TIMER_RUN;
        end else begin
            state_nxt = soc_pkg::TIMER_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= soc_pkg::TIMER_IDLE;
            count <= '0;
        end else begin
            state <= state_nxt;
            // period is compare + 1
            if (hit) begin
                count <= '0;
            end else if (enable) begin
                count <= count + 1'b1;
            end
        end
    end

    assign match = (state == soc_pkg::TIMER_MATCHED);

endmodule

/* timer_regs.sv */
// timer register block
//   bus decode of the 16-byte window
//   control and compare registers, registered read data
//   match clear pulse, irq and done tracking
`timescale 1ns/1ps
`include "soc_consts.svh"

module timer_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  soc_pkg::bus_addr_t    addr,
    input  soc_pkg::bus_data_t    wdata,
    input  logic                  wen,
    input  logic                  ren,
    input  soc_pkg::timer_count_t count,
    input  logic                  match,
    output soc_pkg::bus_data_t    rdata,
    output logic                  done,
    output logic                  active,
    output logic                  enable,
    output soc_pkg::timer_count_t compare,
    output logic                  clear_match,
    output logic                  irq
);

    soc_pkg::bus_addr_t offset;
    logic [3:0]         reg_ofs;
    logic               irq_en;
    soc_pkg::bus_addr_t xact_addr;

    assign active = (addr >= `TIMER_BASE) && (addr < `TIMER_BASE + `TIMER_SPAN);

    assign offset  = addr - `TIMER_BASE;
    assign reg_ofs = offset[3:0];

    // ctrl and compare, written at the sampling edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable  <= 1'b0;
            irq_en  <= 1'b0;
            compare <= '0;
        end else if (wen && active) begin
            case (reg_ofs)
                `TIMER_CTRL_OFS: begin
                    enable <= wdata[0];
                    irq_en <= wdata[1];
                end
                `TIMER_CMP_OFS: compare <= wdata;
                default: ;
            endcase
        end
    end

    // status write of 1 clears match at the same edge
    assign clear_match = wen & active & (reg_ofs == `TIMER_STAT_OFS) & wdata[0];

    // read data, refreshed while the read is held
    always_ff @(posedge clk) begin
        if (ren && active) begin
            case (reg_ofs)
                `TIMER_CTRL_OFS: rdata <= {30'd0, irq_en, enable};
                `TIMER_CMP_OFS:  rdata <= compare;
                `TIMER_CNT_OFS:  rdata <= count;
                `TIMER_STAT_OFS: rdata <= {31'd0, match};
                default:         rdata <= '0;
            endcase
        end
    end

    assign irq = match & irq_en;

    // same done rule as the spram slave
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xact_addr <= `XACT_NONE;
        end else if (ren || wen) begin
            xact_addr <= addr;
        end
    end

    assign done = active & (xact_addr == addr);

endmodule

/* soc_bus_mux.sv */
// slave response mux for the data bus
//   read data from the active slave, or'd done
//   sticky fault on accesses that no slave claims
`timescale 1ns/1ps

module soc_bus_mux (
    input  logic               clk,
    input  logic               rst_n,
    input  soc_pkg::bus_addr_t addr,
    input  logic               wen,
    input  logic               ren,
    input  logic               spram_active,
    input  logic               spram_done,
    input  soc_pkg::bus_data_t spram_rdata,
    input  logic               timer_active,
    input  logic               timer_done,
    input  soc_pkg::bus_data_t timer_rdata,
    output soc_pkg::bus_data_t rdata,
    output logic               done,
    output logic               fault,
    output soc_pkg::bus_addr_t fault_addr
);

    logic unmapped;

    // slave done already carries its own active
    assign done = spram_done | timer_done;

    // windows never overlap
    assign rdata = spram_active ? spram_rdata :
                   timer_active ? timer_rdata : '0;

    assign unmapped = (ren | wen) & ~spram_active & ~timer_active;

    // first unmapped address is kept, flag clears only at reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else if (unmapped) begin
            fault <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (unmapped && !fault) begin
            fault_addr <= addr;
        end
    end

endmodule

/* soc_mem_top.sv */
// data-side memory bus top
//   spram slave, timer registers and counter
//   response mux back to the master
`timescale 1ns/1ps

module soc_mem_top (
    input  logic               clk,
    input  logic               rst_n,
    input  soc_pkg::bus_addr_t addr,
    input  soc_pkg::bus_data_t wdata,
    input  soc_pkg::bus_mask_t wmask,
    input  logic               wen,
    input  logic               ren,
    output soc_pkg::bus_data_t rdata,
    output logic               done,
    output logic               fault,
    output soc_pkg::bus_addr_t fault_addr,
    output logic               irq
);

    soc_pkg::bus_data_t    spram_rdata;
    logic                  spram_done;
    logic                  spram_active;
    soc_pkg::bus_data_t    timer_rdata;
    logic                  timer_done;
    logic                  timer_active;
    logic                  tmr_enable;
    soc_pkg::timer_count_t tmr_compare;
    logic                  tmr_clear;
    soc_pkg::timer_count_t tmr_count;
    logic                  tmr_match;

    // 128 KiB ram, default window
    ice40_spram u_spram (
        .clk    (clk),
        .rst_n  (rst_n),
        .addr   (addr),
        .wdata  (wdata),
        .wmask  (wmask),
        .wen    (wen),
        .ren    (ren),
        .rdata  (spram_rdata),
        .done   (spram_done),
        .active (spram_active)
    );

    // timer registers ignore the byte mask
    timer_regs u_timer_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (addr),
        .wdata       (wdata),
        .wen         (wen),
        .ren         (ren),
        .count       (tmr_count),
        .match       (tmr_match),
        .rdata       (timer_rdata),
        .done        (timer_done),
        .active      (timer_active),
        .enable      (tmr_enable),
        .compare     (tmr_compare),
        .clear_match (tmr_clear),
        .irq         (irq)
    );

    timer_counter u_timer_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (tmr_enable),
        .compare     (tmr_compare),
        .clear_match (tmr_clear),
        .count       (tmr_count),
        .match       (tmr_match)
    );

    soc_bus_mux u_mux (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (addr),
        .wen          (wen),
        .ren          (ren),
        .spram_active (spram_active),
        .spram_done   (spram_done),
        .spram_rdata  (spram_rdata),
        .timer_active (timer_active),
        .timer_done   (timer_done),
        .timer_rdata  (timer_rdata),
        .rdata        (rdata),
        .done         (done),
        .fault        (fault),
        .fault_addr   (fault_addr)
    );

endmodule

/* soc_mem_asserts.sv */
// bus protocol assertions bound into the memory bus top
//   exclusive read and write strobes
//   done quiet in the cycle after reset
//   sticky fault, match raised only by a compare hit
`timescale 1ns/1ps

module soc_mem_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  wen,
    input logic                  ren,
    input logic                  done,
    input logic                  fault,
    input logic                  match,
    input logic                  enable,
    input soc_pkg::timer_count_t count,
    input soc_pkg::timer_count_t compare
);

    // one strobe at a time
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(ren && wen)
    ) else $error("ren and wen high in the same cycle");

    // reset parks every xact_addr at XACT_NONE
    done_low_after_reset: assert property (
        @(posedge clk) !rst_n |=> !done
    ) else $error("done high in the cycle after reset");

    // fault only clears through reset
    fault_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) $past(rst_n) |-> !$fell(fault)
    ) else $error("fault dropped while out of reset");

    // match only rises after the running counter hit compare
    match_from_compare: assert property (
        @(posedge clk) disable iff (!rst_n)
            $rose(match) |-> $past(enable && (count == compare))
    ) else $error("timer match rose without a compare hit");

endmodule

bind soc_mem_top soc_mem_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .wen     (wen),
    .ren     (ren),
    .done    (done),
    .fault   (fault),
    .match   (tmr_match),
    .enable  (tmr_enable),
    .count   (tmr_count),
    .compare (tmr_compare)
);

/* tb_soc_mem.sv */
// testbench for the data-side memory bus
//   clock, reset and falling-edge bus master
//   reference memory model with masked merge
//   read compare process and typed compare tasks
//   timer, fault and reset checks, cycle timeout
`timescale 1ns/1ps
`include "soc_consts.svh"

module tb_soc_mem;

    localparam int N_RAND  = 16;
    localparam int N_MERGE = 8;
    // largest timer compare drawn
    localparam int CMP_MAX = 31;
    // random, merge, edge, timer and tail accesses
    localparam int ACCESSES = 2 * N_RAND + 3 * N_MERGE + 5 + 12 + 4;
    // separating reads can double the access count
    localparam int CYCLE_LIMIT = 2 * ACCESSES * 8 + 2 * (CMP_MAX + 5) + 5;

    localparam soc_pkg::bus_addr_t SPRAM_FIRST = `SPRAM_BASE;
    localparam soc_pkg::bus_addr_t SPRAM_END   = `SPRAM_BASE + `SPRAM_WORDS * 4;
    localparam soc_pkg::bus_addr_t SPRAM_LAST  = SPRAM_END - 32'd4;
    localparam soc_pkg::bus_addr_t CTRL_ADDR   = `TIMER_BASE + 32'(`TIMER_CTRL_OFS);
    localparam soc_pkg::bus_addr_t CMP_ADDR    = `TIMER_BASE + 32'(`TIMER_CMP_OFS);
    localparam soc_pkg::bus_addr_t CNT_ADDR    = `TIMER_BASE + 32'(`TIMER_CNT_OFS);
    localparam soc_pkg::bus_addr_t STAT_ADDR   = `TIMER_BASE + 32'(`TIMER_STAT_OFS);

    logic               clk;
    logic               rst_n;
    soc_pkg::bus_addr_t addr;
    soc_pkg::bus_data_t wdata;
    soc_pkg::bus_mask_t wmask;
    logic               wen;
    logic               ren;
    soc_pkg::bus_data_t rdata;
    logic               done;
    logic               fault;
    soc_pkg::bus_addr_t fault_addr;
    logic               irq;

    // expected read data handed to the compare process
    logic               rd_check;
    soc_pkg::bus_data_t rd_expect;

    // reference state
    soc_pkg::bus_data_t mem_model [soc_pkg::bus_addr_t];
    soc_pkg::bus_data_t ctrl_model;
    soc_pkg::bus_data_t cmp_model;
    soc_pkg::bus_addr_t last_addr;
    logic [31:0]        rng;

    int data_errs  = 0;
    int addr_errs  = 0;
    int bit_errs   = 0;
    int other_errs = 0;
    int cycle_cnt;

    soc_mem_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .wdata      (wdata),
        .wmask      (wmask),
        .wen        (wen),
        .ren        (ren),
        .rdata      (rdata),
        .done       (done),
        .fault      (fault),
        .fault_addr (fault_addr),
        .irq        (irq)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // byte lanes with a set mask bit take the new data
    function automatic soc_pkg::bus_data_t merge_word(input soc_pkg::bus_data_t old_w,
                                                      input soc_pkg::bus_data_t new_w,
                                                      input soc_pkg::bus_mask_t m);
        soc_pkg::bus_data_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                w[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return w;
    endfunction

    task automatic check_data(input string name, input soc_pkg::bus_data_t got,
                              input soc_pkg::bus_data_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_addr(input string name, input soc_pkg::bus_addr_t got,
                              input soc_pkg::bus_addr_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            addr_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            bit_errs++;
        end
    endtask

    // one access, held until done or four edges
    task automatic bus_cycle(input soc_pkg::bus_addr_t a, input logic is_wr,
                             input soc_pkg::bus_data_t wd, input soc_pkg::bus_mask_t wm,
                             input logic chk, input soc_pkg::bus_data_t exp,
                             output soc_pkg::bus_data_t got);
        int edges;
        edges = 0;
        @(negedge clk);
        addr      = a;
        wdata     = wd;
        wmask     = wm;
        wen       = is_wr;
        ren       = ~is_wr;
        rd_check  = chk & ~is_wr;
        rd_expect = exp;
        do begin
            @(posedge clk);
            edges++;
        end while (!done && edges < 4);
        got       = rdata;
        last_addr = a;
        if (!done) begin
            $display("access to %h never got done", a);
            other_errs++;
        end else if (edges != 2) begin
            $display("done for %h seen at edge %0d, one cycle after the strobe expected",
                     a, edges);
            other_errs++;
        end
        @(negedge clk);
        wen      = 1'b0;
        ren      = 1'b0;
        rd_check = 1'b0;
    endtask

    // a repeated address would look done at once, so touch a timer register first
    task automatic break_repeat(input soc_pkg::bus_addr_t a);
        soc_pkg::bus_addr_t alt;
        soc_pkg::bus_data_t dummy;
        if (a == last_addr) begin
            alt = (a == CTRL_ADDR) ? CMP_ADDR : CTRL_ADDR;
            bus_cycle(alt, 1'b0, '0, '0, 1'b1,
                      (alt == CTRL_ADDR) ? ctrl_model : cmp_model, dummy);
        end
    endtask

    task automatic mem_write(input soc_pkg::bus_addr_t a, input soc_pkg::bus_data_t d,
                             input soc_pkg::bus_mask_t m);
        soc_pkg::bus_data_t old_w;
        soc_pkg::bus_data_t dummy;
        old_w = mem_model.exists(a) ? mem_model[a] : 'x;
        mem_model[a] = merge_word(old_w, d, m);
        break_repeat(a);
        bus_cycle(a, 1'b1, d, m, 1'b0, '0, dummy);
    endtask

    task automatic mem_read(input soc_pkg::bus_addr_t a);
        soc_pkg::bus_data_t got;
        break_repeat(a);
        bus_cycle(a, 1'b0, '0, '0, 1'b1, mem_model[a], got);
    endtask

    task automatic reg_write(input soc_pkg::bus_addr_t a, input soc_pkg::bus_data_t d);
        soc_pkg::bus_data_t dummy;
        if (a == CTRL_ADDR) begin
            ctrl_model = {30'd0, d[1:0]};
        end else if (a == CMP_ADDR) begin
            cmp_model = d;
        end
        break_repeat(a);
        bus_cycle(a, 1'b1, d, 4'hf, 1'b0, '0, dummy);
    endtask

    task automatic reg_read(input soc_pkg::bus_addr_t a, input soc_pkg::bus_data_t exp,
                            input logic chk, output soc_pkg::bus_data_t got);
        break_repeat(a);
        bus_cycle(a, 1'b0, '0, '0, chk, exp, got);
    endtask

    // no slave answers, the master gives up after four edges
    task automatic unmapped_access(input soc_pkg::bus_addr_t a, input logic is_wr);
        int fault_edge;
        fault_edge = 0;
        @(negedge clk);
        addr     = a;
        wdata    = rng;
        wmask    = 4'hf;
        wen      = is_wr;
        ren      = ~is_wr;
        rd_check = 1'b0;
        for (int e = 1; e <= 4; e++) begin
            @(posedge clk);
            if (done) begin
                $display("done rose for unmapped address %h", a);
                other_errs++;
            end
            if (fault && fault_edge == 0) begin
                fault_edge = e;
            end
        end
        last_addr = a;
        if (fault_edge != 2) begin
            $display("fault for %h seen at edge %0d, one cycle after the strobe expected",
                     a, fault_edge);
            other_errs++;
        end
        @(negedge clk);
        wen = 1'b0;
        ren = 1'b0;
    endtask

    // read data is checked at the edge where done is seen
    always @(posedge clk) begin
        if (rst_n && ren && done && rd_check) begin
            check_data("rdata", rdata, rd_expect);
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        soc_pkg::bus_addr_t    addr_list [N_RAND];
        soc_pkg::bus_addr_t    a;
        soc_pkg::bus_data_t    d;
        soc_pkg::bus_data_t    got;
        soc_pkg::timer_count_t cmp_val;
        int                    edges;
        logic                  irq_seen;
        int                    total;

        // master idle from time zero, address parked inside the ram window
        rst_n      = 1'b0;
        addr       = SPRAM_FIRST;
        wdata      = '0;
        wmask      = '0;
        wen        = 1'b0;
        ren        = 1'b0;
        rd_check   = 1'b0;
        rd_expect  = '0;
        ctrl_model = '0;
        cmp_model  = '0;
        last_addr  = `XACT_NONE;
        rng        = 32'hfa90e1ab;

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // quiet outputs out of reset
        @(posedge clk);
        check_bit("done", done, 1'b0);
        check_bit("fault", fault, 1'b0);
        check_bit("irq", irq, 1'b0);

        // full words, bank picked by the loop index
        for (int i = 0; i < N_RAND; i++) begin
            rng = xorshift32(rng);
            a = `SPRAM_BASE + {15'd0, i[0], rng[15:2], 2'b00};
            addr_list[i] = a;
            rng = xorshift32(rng);
            mem_write(a, rng, 4'hf);
        end
        for (int i = 0; i < N_RAND; i++) begin
            mem_read(addr_list[i]);
        end

        // byte mask merge over a known word
        for (int i = 0; i < N_MERGE; i++) begin
            rng = xorshift32(rng);
            a = `SPRAM_BASE + {15'd0, rng[16:2], 2'b00};
            rng = xorshift32(rng);
            mem_write(a, rng, 4'hf);
            rng = xorshift32(rng);
            d = rng;
            rng = xorshift32(rng);
            mem_write(a, d, rng[3:0]);
            mem_read(a);
        end

        // window edges, then one word past the end
        rng = xorshift32(rng);
        mem_write(SPRAM_FIRST, rng, 4'hf);
        rng = xorshift32(rng);
        mem_write(SPRAM_LAST, rng, 4'hf);
        mem_read(SPRAM_FIRST);
        mem_read(SPRAM_LAST);
        unmapped_access(SPRAM_END, 1'b1);
        check_bit("fault", fault, 1'b1);
        check_addr("fault_addr", fault_addr, SPRAM_END);

        // timer readback and compare match
        rng = xorshift32(rng);
        cmp_val = 32'd8 + (rng % 32'd24);
        reg_write(CMP_ADDR, cmp_val);
        reg_read(CMP_ADDR, cmp_val, 1'b1, got);
        reg_write(CTRL_ADDR, 32'd3);
        edges = 0;
        while (!irq && edges < int'(cmp_val) + 3) begin
            @(posedge clk);
            edges++;
        end
        if (!irq) begin
            $display("irq did not rise within %0d cycles of enabling the timer",
                     int'(cmp_val) + 3);
            other_errs++;
        end
        reg_read(CTRL_ADDR, 32'd3, 1'b1, got);
        reg_read(STAT_ADDR, 32'd1, 1'b1, got);
        // count value depends on phase, only its range is known
        reg_read(CNT_ADDR, '0, 1'b0, got);
        if (got > cmp_val) begin
            $display("count register read %0d, above the compare value %0d", got, cmp_val);
            other_errs++;
        end

        // stop counting, match stays until the status write
        reg_write(CTRL_ADDR, 32'd2);
        check_bit("irq", irq, 1'b1);
        reg_write(STAT_ADDR, 32'd1);
        check_bit("irq", irq, 1'b0);
        reg_read(STAT_ADDR, 32'd0, 1'b1, got);
        irq_seen = 1'b0;
        repeat (int'(cmp_val) + 5) begin
            @(negedge clk);
            irq_seen = irq_seen | irq;
        end
        check_bit("irq", irq_seen, 1'b0);

        // fault survives valid traffic
        mem_read(addr_list[0]);
        reg_read(CMP_ADDR, cmp_model, 1'b1, got);
        check_bit("fault", fault, 1'b1);
        check_addr("fault_addr", fault_addr, SPRAM_END);

        total = data_errs + addr_errs + bit_errs + other_errs;
        $display("errors: data %0d, addr %0d, bit %0d, other %0d, total %0d",
                 data_errs, addr_errs, bit_errs, other_errs, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
soc_pkg.sv
spram_256k.sv
ice40_spram.sv
timer_counter.sv
timer_regs.sv
soc_bus_mux.sv
soc_mem_top.sv
soc_mem_asserts.sv
tb_soc_mem.sv

/* Makefile */
# Verilator build and run for the data-side memory bus testbench

SRCS = soc_consts.svh soc_pkg.sv spram_256k.sv ice40_spram.sv timer_counter.sv \
       timer_regs.sv soc_bus_mux.sv soc_mem_top.sv soc_mem_asserts.sv tb_soc_mem.sv

obj_dir/Vtb_soc_mem: $(SRCS) flist.f
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_soc_mem

run: obj_dir/Vtb_soc_mem
	./obj_dir/Vtb_soc_mem | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
